// ==== src/mul_rs_pkg.sv ====
package mul_rs_pkg;

    localparam int RS_DEPTH = 16;
    localparam int PTR_W    = 4;
    localparam int CNT_W    = PTR_W + 1;    // Occupancy must reach RS_DEPTH
    localparam int TAG_W    = 8;
    localparam int PC_W     = 32;
    localparam int NUM_WAKE = 7;            // ALU, MUL, DIV, load, branch, P unit, CSR

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [PTR_W-1:0] ptr_t;

    // One producer's result broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } wake_bcast_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        tag_t            rd;
        tag_t            src1;
        tag_t            src2;
        logic            src1_rdy;
        logic            src2_rdy;
    } rs_dispatch_t;

    // Word handed to the multiplier
    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        tag_t            rd;
        tag_t            src1;
        tag_t            src2;
    } rs_issue_t;

endpackage

// ==== src/rs_queue_ctrl.sv ====
`timescale 1ns/1ps

module rs_queue_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dispatch_valid,
    input  logic                            exception_sig,
    input  logic                            mret_sig,
    input  logic [mul_rs_pkg::RS_DEPTH-1:0] entry_valid,
    input  logic                            issue_en,
    output logic                            alloc_en,
    output mul_rs_pkg::ptr_t                alloc_ptr,
    output mul_rs_pkg::ptr_t                head,
    output logic                            flush,
    output logic                            full
);

    mul_rs_pkg::ptr_t             tail;
    logic [mul_rs_pkg::CNT_W-1:0] occ_cnt;    // Head to tail, holes included
    logic [mul_rs_pkg::CNT_W-1:0] live_cnt;   // Entries not yet issued
    logic                         head_adv;

    assign flush     = exception_sig | mret_sig;
    assign full      = (occ_cnt == mul_rs_pkg::CNT_W'(mul_rs_pkg::RS_DEPTH));
    assign alloc_en  = dispatch_valid && !full && !flush;
    assign alloc_ptr = tail;

    // Reclaim one hole per cycle, head slot already issued
    assign head_adv = (occ_cnt != '0) && !entry_valid[head] && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head     <= '0;
            tail     <= '0;
            occ_cnt  <= '0;
            live_cnt <= '0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (head_adv) begin
                head <= head + 1'b1;
            end

            case ({alloc_en, head_adv})
                2'b10:   occ_cnt <= occ_cnt + 1'b1;
                2'b01:   occ_cnt <= occ_cnt - 1'b1;
                default: occ_cnt <= occ_cnt;
            endcase

            case ({alloc_en, issue_en})
                2'b10:   live_cnt <= live_cnt + 1'b1;
                2'b01:   live_cnt <= live_cnt - 1'b1;
                default: live_cnt <= live_cnt;
            endcase
        end
    end

    // Upstream must honor the full level
    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (reset)
        dispatch_valid |-> !full
    );

    // Live count tracks the array's valid bits and stays inside the window
    a_occupancy: assert property (
        @(posedge clk) disable iff (reset)
        (occ_cnt <= mul_rs_pkg::RS_DEPTH) && (live_cnt <= occ_cnt) &&
        (live_cnt == $countones(entry_valid))
    );

endmodule

// ==== src/rs_entry_array.sv ====
`timescale 1ns/1ps

module rs_entry_array (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic                              alloc_en,
    input  mul_rs_pkg::ptr_t                  alloc_ptr,
    input  mul_rs_pkg::rs_dispatch_t          dispatch,
    input  logic                              bypass1,
    input  logic                              bypass2,
    input  logic [mul_rs_pkg::RS_DEPTH-1:0]   wake1,
    input  logic [mul_rs_pkg::RS_DEPTH-1:0]   wake2,
    input  logic                              issue_en,
    input  mul_rs_pkg::ptr_t                  issue_ptr,
    output logic [mul_rs_pkg::RS_DEPTH-1:0]   entry_valid,
    output logic [mul_rs_pkg::RS_DEPTH-1:0]   entry_ready,
    output mul_rs_pkg::tag_t                  src1_tags [mul_rs_pkg::RS_DEPTH],
    output mul_rs_pkg::tag_t                  src2_tags [mul_rs_pkg::RS_DEPTH],
    output logic [mul_rs_pkg::PC_W-1:0]       pcs [mul_rs_pkg::RS_DEPTH],
    output mul_rs_pkg::tag_t                  rds [mul_rs_pkg::RS_DEPTH]
);

    logic [mul_rs_pkg::RS_DEPTH-1:0] rdy1;    // Source 1 value available
    logic [mul_rs_pkg::RS_DEPTH-1:0] rdy2;

    assign entry_ready = entry_valid & rdy1 & rdy2;

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            pcs[alloc_ptr]       <= dispatch.pc;
            rds[alloc_ptr]       <= dispatch.rd;
            src1_tags[alloc_ptr] <= dispatch.src1;
            src2_tags[alloc_ptr] <= dispatch.src2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            entry_valid <= '0;
            rdy1        <= '0;
            rdy2        <= '0;
        end else begin
            // Wake bits only hit valid entries
            rdy1 <= rdy1 | wake1;
            rdy2 <= rdy2 | wake2;

            if (alloc_en) begin
                entry_valid[alloc_ptr] <= 1'b1;
                rdy1[alloc_ptr]        <= dispatch.src1_rdy | bypass1;
                rdy2[alloc_ptr]        <= dispatch.src2_rdy | bypass2;
            end

            if (issue_en) begin
                entry_valid[issue_ptr] <= 1'b0;
                rdy1[issue_ptr]        <= 1'b0;
                rdy2[issue_ptr]        <= 1'b0;
            end
        end
    end

    // Tail never wraps onto a live entry
    a_alloc_free_slot: assert property (
        @(posedge clk) disable iff (reset)
        alloc_en |-> !entry_valid[alloc_ptr]
    );

endmodule

// ==== src/rs_tag_wakeup.sv ====
`timescale 1ns/1ps

module rs_tag_wakeup (
    input  mul_rs_pkg::wake_bcast_t         wake_bus [mul_rs_pkg::NUM_WAKE],
    input  logic [mul_rs_pkg::RS_DEPTH-1:0] entry_valid,
    input  mul_rs_pkg::tag_t                src1_tags [mul_rs_pkg::RS_DEPTH],
    input  mul_rs_pkg::tag_t                src2_tags [mul_rs_pkg::RS_DEPTH],
    input  mul_rs_pkg::rs_dispatch_t        dispatch,
    output logic [mul_rs_pkg::RS_DEPTH-1:0] wake1,
    output logic [mul_rs_pkg::RS_DEPTH-1:0] wake2,
    output logic                            bypass1,
    output logic                            bypass2
);

    // Any valid broadcast carrying this tag
    function automatic logic tag_hit(
        input mul_rs_pkg::tag_t        tag,
        input mul_rs_pkg::wake_bcast_t bus [mul_rs_pkg::NUM_WAKE]
    );
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < mul_rs_pkg::NUM_WAKE; k++) begin
            hit = hit | (bus[k].valid && (bus[k].tag == tag));
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < mul_rs_pkg::RS_DEPTH; i++) begin
            wake1[i] = entry_valid[i] && tag_hit(src1_tags[i], wake_bus);
            wake2[i] = entry_valid[i] && tag_hit(src2_tags[i], wake_bus);
        end
    end

    // Same-cycle result for the instruction being written
    assign bypass1 = tag_hit(dispatch.src1, wake_bus);
    assign bypass2 = tag_hit(dispatch.src2, wake_bus);

endmodule

// ==== src/rs_issue_select.sv ====
`timescale 1ns/1ps

module rs_issue_select (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,
    input  mul_rs_pkg::ptr_t                head,
    input  logic [mul_rs_pkg::RS_DEPTH-1:0] entry_ready,
    input  logic [mul_rs_pkg::PC_W-1:0]     pcs [mul_rs_pkg::RS_DEPTH],
    input  mul_rs_pkg::tag_t                rds [mul_rs_pkg::RS_DEPTH],
    input  mul_rs_pkg::tag_t                src1_tags [mul_rs_pkg::RS_DEPTH],
    input  mul_rs_pkg::tag_t                src2_tags [mul_rs_pkg::RS_DEPTH],
    output logic                            issue_en,
    output mul_rs_pkg::ptr_t                issue_ptr,
    output mul_rs_pkg::rs_issue_t           issue
);

    logic [2*mul_rs_pkg::RS_DEPTH-1:0] ready_dbl;
    logic [mul_rs_pkg::RS_DEPTH-1:0]   rot_ready;   // Bit 0 is the head slot
    mul_rs_pkg::ptr_t                  offset;

    assign ready_dbl = {entry_ready, entry_ready} >> head;
    assign rot_ready = ready_dbl[mul_rs_pkg::RS_DEPTH-1:0];

    // Lowest set bit is the oldest ready entry
    always_comb begin
        offset = '0;
        for (int j = mul_rs_pkg::RS_DEPTH - 1; j >= 0; j--) begin
            if (rot_ready[j]) begin
                offset = mul_rs_pkg::ptr_t'(j);
            end
        end
    end

    assign issue_en  = (|rot_ready) && !flush;
    assign issue_ptr = head + offset;    // Wraps with the pointer width

    always_ff @(posedge clk) begin
        if (reset) begin
            issue <= '0;
        end else if (issue_en) begin
            issue <= '{
                valid: 1'b1,
                pc:    pcs[issue_ptr],
                rd:    rds[issue_ptr],
                src1:  src1_tags[issue_ptr],
                src2:  src2_tags[issue_ptr]
            };
        end else begin
            issue <= '0;    // Idle and flush cycles
        end
    end

    // Issued slot is freed and never picked twice
    a_issue_ready: assert property (
        @(posedge clk) disable iff (reset)
        issue_en |=> !entry_ready[$past(issue_ptr)]
    );

endmodule

// ==== src/mul_reservation_station.sv ====
`timescale 1ns/1ps

module mul_reservation_station (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  mul_rs_pkg::rs_dispatch_t  dispatch,
    input  mul_rs_pkg::wake_bcast_t   wake_bus [mul_rs_pkg::NUM_WAKE],
    input  logic                      exception_sig,
    input  logic                      mret_sig,
    output mul_rs_pkg::rs_issue_t     issue,
    output logic                      full
);

    mul_rs_pkg::ptr_t                alloc_ptr;
    mul_rs_pkg::ptr_t                head;
    mul_rs_pkg::ptr_t                issue_ptr;
    logic                            alloc_en;
    logic                            flush;
    logic                            issue_en;
    logic                            bypass1;
    logic                            bypass2;
    logic [mul_rs_pkg::RS_DEPTH-1:0] entry_valid;
    logic [mul_rs_pkg::RS_DEPTH-1:0] entry_ready;
    logic [mul_rs_pkg::RS_DEPTH-1:0] wake1;
    logic [mul_rs_pkg::RS_DEPTH-1:0] wake2;
    mul_rs_pkg::tag_t                src1_tags [mul_rs_pkg::RS_DEPTH];
    mul_rs_pkg::tag_t                src2_tags [mul_rs_pkg::RS_DEPTH];
    mul_rs_pkg::tag_t                rds [mul_rs_pkg::RS_DEPTH];
    logic [mul_rs_pkg::PC_W-1:0]     pcs [mul_rs_pkg::RS_DEPTH];

    rs_queue_ctrl u_queue_ctrl (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .exception_sig  (exception_sig),
        .mret_sig       (mret_sig),
        .entry_valid    (entry_valid),
        .issue_en       (issue_en),
        .alloc_en       (alloc_en),
        .alloc_ptr      (alloc_ptr),
        .head           (head),
        .flush          (flush),
        .full           (full)
    );

    rs_entry_array u_entry_array (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .alloc_en    (alloc_en),
        .alloc_ptr   (alloc_ptr),
        .dispatch    (dispatch),
        .bypass1     (bypass1),
        .bypass2     (bypass2),
        .wake1       (wake1),
        .wake2       (wake2),
        .issue_en    (issue_en),
        .issue_ptr   (issue_ptr),
        .entry_valid (entry_valid),
        .entry_ready (entry_ready),
        .src1_tags   (src1_tags),
        .src2_tags   (src2_tags),
        .pcs         (pcs),
        .rds         (rds)
    );

    rs_tag_wakeup u_tag_wakeup (
        .wake_bus    (wake_bus),
        .entry_valid (entry_valid),
        .src1_tags   (src1_tags),
        .src2_tags   (src2_tags),
        .dispatch    (dispatch),
        .wake1       (wake1),
        .wake2       (wake2),
        .bypass1     (bypass1),
        .bypass2     (bypass2)
    );

    rs_issue_select u_issue_select (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .head        (head),
        .entry_ready (entry_ready),
        .pcs         (pcs),
        .rds         (rds),
        .src1_tags   (src1_tags),
        .src2_tags   (src2_tags),
        .issue_en    (issue_en),
        .issue_ptr   (issue_ptr),
        .issue       (issue)
    );

endmodule

// ==== verif/mul_rs_tb.sv ====
`timescale 1ns/1ps

module mul_rs_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 500;    // Directed tests plus their drain limits
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MARGIN_CYCLES   = 200;
    localparam int DRAIN_LIMIT     = 40;

    logic                      clk;
    logic                      reset;
    logic                      dispatch_valid;
    mul_rs_pkg::rs_dispatch_t  dispatch;
    mul_rs_pkg::wake_bcast_t   wake_bus [mul_rs_pkg::NUM_WAKE];
    logic                      exception_sig;
    logic                      mret_sig;
    mul_rs_pkg::rs_issue_t     issue;
    logic                      full;

    logic [mul_rs_pkg::RS_DEPTH-1:0] m_valid;    // Reference model state
    logic [mul_rs_pkg::RS_DEPTH-1:0] m_rdy1;
    logic [mul_rs_pkg::RS_DEPTH-1:0] m_rdy2;
    logic [mul_rs_pkg::PC_W-1:0]     m_pc [mul_rs_pkg::RS_DEPTH];
    mul_rs_pkg::tag_t                m_rd [mul_rs_pkg::RS_DEPTH];
    mul_rs_pkg::tag_t                m_src1 [mul_rs_pkg::RS_DEPTH];
    mul_rs_pkg::tag_t                m_src2 [mul_rs_pkg::RS_DEPTH];
    int                              m_head;
    int                              m_tail;
    int                              m_occ;    // Head to tail including holes

    mul_rs_pkg::rs_issue_t exp_issue;
    logic                  exp_full;
    logic                  model_started;
    string                 test_name;

    mul_reservation_station DUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .wake_bus       (wake_bus),
        .exception_sig  (exception_sig),
        .mret_sig       (mret_sig),
        .issue          (issue),
        .full           (full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic broadcast_hit(input mul_rs_pkg::tag_t tag);
        for (int k = 0; k < mul_rs_pkg::NUM_WAKE; k++) begin
            if (wake_bus[k].valid && (wake_bus[k].tag == tag)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // One rising edge of the station and the issue word it leaves
    function automatic mul_rs_pkg::rs_issue_t ref_step(
        input logic                     rst,
        input logic                     flush,
        input logic                     disp_v,
        input mul_rs_pkg::rs_dispatch_t disp
    );
        mul_rs_pkg::rs_issue_t           res;
        logic [mul_rs_pkg::RS_DEPTH-1:0] nxt_valid;
        logic [mul_rs_pkg::RS_DEPTH-1:0] nxt_rdy1;
        logic [mul_rs_pkg::RS_DEPTH-1:0] nxt_rdy2;
        logic                            alloc;
        logic                            reclaim;
        int                              sel;
        int                              idx;

        res = '0;
        if (rst || flush) begin
            m_valid = '0;
            m_rdy1  = '0;
            m_rdy2  = '0;
            m_head  = 0;
            m_tail  = 0;
            m_occ   = 0;
            return res;
        end

        alloc   = disp_v && (m_occ != mul_rs_pkg::RS_DEPTH);
        reclaim = (m_occ != 0) && !m_valid[m_head];

        sel = -1;    // Oldest ready entry from the head
        for (int k = 0; k < mul_rs_pkg::RS_DEPTH; k++) begin
            idx = (m_head + k) % mul_rs_pkg::RS_DEPTH;
            if ((sel < 0) && m_valid[idx] && m_rdy1[idx] && m_rdy2[idx]) begin
                sel = idx;
            end
        end

        nxt_valid = m_valid;
        nxt_rdy1  = m_rdy1;
        nxt_rdy2  = m_rdy2;
        for (int i = 0; i < mul_rs_pkg::RS_DEPTH; i++) begin
            if (m_valid[i] && broadcast_hit(m_src1[i])) begin
                nxt_rdy1[i] = 1'b1;
            end
            if (m_valid[i] && broadcast_hit(m_src2[i])) begin
                nxt_rdy2[i] = 1'b1;
            end
        end

        if (sel >= 0) begin
            res.valid      = 1'b1;
            res.pc         = m_pc[sel];
            res.rd         = m_rd[sel];
            res.src1       = m_src1[sel];
            res.src2       = m_src2[sel];
            nxt_valid[sel] = 1'b0;
            nxt_rdy1[sel]  = 1'b0;
            nxt_rdy2[sel]  = 1'b0;
        end

        if (alloc) begin
            m_pc[m_tail]      = disp.pc;
            m_rd[m_tail]      = disp.rd;
            m_src1[m_tail]    = disp.src1;
            m_src2[m_tail]    = disp.src2;
            nxt_valid[m_tail] = 1'b1;
            nxt_rdy1[m_tail]  = disp.src1_rdy || broadcast_hit(disp.src1);    // Same-cycle bypass
            nxt_rdy2[m_tail]  = disp.src2_rdy || broadcast_hit(disp.src2);
            m_tail            = (m_tail + 1) % mul_rs_pkg::RS_DEPTH;
            m_occ++;
        end
        if (reclaim) begin
            m_head = (m_head + 1) % mul_rs_pkg::RS_DEPTH;
            m_occ--;
        end

        m_valid = nxt_valid;
        m_rdy1  = nxt_rdy1;
        m_rdy2  = nxt_rdy2;
        return res;
    endfunction

    task automatic check_issue(
        input string                 name,
        input mul_rs_pkg::rs_issue_t exp_val,
        input mul_rs_pkg::rs_issue_t act_val
    );
        if (act_val !== exp_val) begin
            $display("Mismatch in %s at %0t: issue expected %h, actual %h",
                     name, $time, exp_val, act_val);
            $display("SIMULATION FAILED");
            $fatal(1, "issue word differs from the model");
        end
    endtask

    task automatic check_full(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch in %s at %0t: full expected %b, actual %b",
                     name, $time, exp_val, act_val);
            $display("SIMULATION FAILED");
            $fatal(1, "full level differs from the model");
        end
    endtask

    always @(posedge clk) begin
        exp_issue     = ref_step(reset, exception_sig || mret_sig, dispatch_valid, dispatch);
        exp_full      = (m_occ == mul_rs_pkg::RS_DEPTH);
        model_started = 1'b1;
    end

    always @(negedge clk) begin
        if (model_started) begin
            check_issue(test_name, exp_issue, issue);
            check_full(test_name, exp_full, full);
        end
    end

    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish in the expected time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic clear_inputs();
        dispatch_valid = 1'b0;
        dispatch       = '0;
        exception_sig  = 1'b0;
        mret_sig       = 1'b0;
        for (int k = 0; k < mul_rs_pkg::NUM_WAKE; k++) begin
            wake_bus[k] = '0;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic send_dispatch(
        input logic [mul_rs_pkg::PC_W-1:0] pc,
        input mul_rs_pkg::tag_t            rd,
        input mul_rs_pkg::tag_t            src1,
        input mul_rs_pkg::tag_t            src2,
        input logic                        src1_rdy,
        input logic                        src2_rdy
    );
        dispatch_valid    = 1'b1;
        dispatch.pc       = pc;
        dispatch.rd       = rd;
        dispatch.src1     = src1;
        dispatch.src2     = src2;
        dispatch.src1_rdy = src1_rdy;
        dispatch.src2_rdy = src2_rdy;
    endtask

    task automatic send_broadcast(input int port, input mul_rs_pkg::tag_t tag);
        wake_bus[port].valid = 1'b1;
        wake_bus[port].tag   = tag;
    endtask

    // Idle until every entry has issued and the head has caught up
    task automatic wait_empty(input int limit);
        int cycles;
        cycles = 0;
        next_cycle();
        while (m_occ != 0) begin
            if (cycles >= limit) begin
                $display("Timeout in %s: station still holds entries after %0d cycles",
                         test_name, limit);
                $display("SIMULATION FAILED");
                $fatal(1, "drain timeout");
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic ready_at_dispatch_test();
        test_name = "ready_at_dispatch";
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            send_dispatch(32'h1000 + 32'(4 * i), mul_rs_pkg::tag_t'(8'h40 + i),
                          mul_rs_pkg::tag_t'(8'h01 + i), mul_rs_pkg::tag_t'(8'h02 + i),
                          1'b1, 1'b1);
        end
        wait_empty(DRAIN_LIMIT);
    endtask

    task automatic wakeup_test();
        test_name = "wakeup";
        for (int p = 0; p < mul_rs_pkg::NUM_WAKE; p++) begin
            next_cycle();
            send_dispatch(32'h2000 + 32'(4 * p), mul_rs_pkg::tag_t'(8'h50 + p),
                          mul_rs_pkg::tag_t'(8'h30 + p), 8'h0f, 1'b0, 1'b1);
        end
        next_cycle();
        send_dispatch(32'h2100, 8'h5f, 8'h01, 8'h02, 1'b1, 1'b1);    // Youngest entry issues first
        // Reverse order so younger entries pass older ones
        for (int p = mul_rs_pkg::NUM_WAKE - 1; p >= 0; p--) begin
            next_cycle();
            send_broadcast(p, mul_rs_pkg::tag_t'(8'h30 + p));
        end
        wait_empty(DRAIN_LIMIT);
    endtask

    task automatic bypass_test();
        mul_rs_pkg::rs_issue_t want;
        test_name  = "dispatch_bypass";
        want.valid = 1'b1;
        want.pc    = 32'h3000;
        want.rd    = 8'h60;
        want.src1  = 8'h38;
        want.src2  = 8'h39;
        next_cycle();
        send_dispatch(32'h3000, 8'h60, 8'h38, 8'h39, 1'b0, 1'b0);
        send_broadcast(1, 8'h38);
        send_broadcast(4, 8'h39);
        next_cycle();
        send_dispatch(32'h3004, 8'h61, 8'h3a, 8'h3b, 1'b0, 1'b0);
        send_broadcast(2, 8'h3a);    // Second source comes later
        next_cycle();
        check_issue(test_name, want, issue);
        next_cycle();
        send_broadcast(5, 8'h3b);
        wait_empty(DRAIN_LIMIT);
    endtask

    task automatic full_reclaim_test();
        test_name = "full_and_reclaim";
        for (int i = 0; i < mul_rs_pkg::RS_DEPTH; i++) begin
            next_cycle();
            send_dispatch(32'h4000 + 32'(4 * i), mul_rs_pkg::tag_t'(8'h80 + i),
                          mul_rs_pkg::tag_t'(8'h90 + i), 8'h0f, 1'b0, 1'b1);
        end
        next_cycle();
        check_full(test_name, 1'b1, full);
        send_broadcast(0, 8'h98);    // Middle entry leaves a hole
        repeat (4) next_cycle();
        check_full(test_name, 1'b1, full);
        send_broadcast(3, 8'h90);    // Head entry
        repeat (4) next_cycle();
        check_full(test_name, 1'b0, full);
        for (int i = 1; i < mul_rs_pkg::RS_DEPTH; i++) begin
            if (i != 8) begin
                next_cycle();
                send_broadcast(i % mul_rs_pkg::NUM_WAKE, mul_rs_pkg::tag_t'(8'h90 + i));
            end
        end
        wait_empty(DRAIN_LIMIT);
    endtask

    task automatic flush_test(input string name, input logic use_mret);
        test_name = name;
        for (int i = 0; i < mul_rs_pkg::RS_DEPTH - 1; i++) begin
            next_cycle();
            send_dispatch(32'h5000 + 32'(4 * i), mul_rs_pkg::tag_t'(8'ha0 + i),
                          mul_rs_pkg::tag_t'(8'hb0 + i), mul_rs_pkg::tag_t'(8'hc0 + i),
                          1'b0, 1'b0);
        end
        next_cycle();
        send_dispatch(32'h5100, 8'haf, 8'h01, 8'h02, 1'b1, 1'b1);    // Due at the flush edge
        next_cycle();
        check_full(test_name, 1'b1, full);
        exception_sig = !use_mret;
        mret_sig      = use_mret;
        for (int c = 0; c < 6; c++) begin
            next_cycle();
            check_issue(test_name, '0, issue);
            check_full(test_name, 1'b0, full);
            if (c < 4) begin
                send_broadcast(0, mul_rs_pkg::tag_t'(8'hb0 + c));
                send_broadcast(1, mul_rs_pkg::tag_t'(8'hc0 + c));
            end
        end
        wait_empty(DRAIN_LIMIT);
    endtask

    task automatic random_test();
        test_name = "random_mix";
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_cycle();
            if (!full && ($urandom % 3 != 0)) begin
                send_dispatch($urandom, mul_rs_pkg::tag_t'($urandom),
                              mul_rs_pkg::tag_t'($urandom % 24),
                              mul_rs_pkg::tag_t'($urandom % 24),
                              ($urandom % 4) == 0, ($urandom % 4) == 0);
            end
            for (int p = 0; p < mul_rs_pkg::NUM_WAKE; p++) begin
                if ($urandom % 4 == 0) begin
                    send_broadcast(p, mul_rs_pkg::tag_t'($urandom % 24));
                end
            end
            if ($urandom % 250 == 0) begin
                if ($urandom % 2 == 0) begin
                    exception_sig = 1'b1;
                end else begin
                    mret_sig = 1'b1;
                end
            end
        end
        next_cycle();
        exception_sig = 1'b1;    // Drop entries whose tags never return
        wait_empty(DRAIN_LIMIT);
    endtask

    initial begin
        void'($urandom(5891));
        clk           = 1'b0;
        reset         = 1'b1;
        model_started = 1'b0;
        test_name     = "reset";
        clear_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        ready_at_dispatch_test();
        wakeup_test();
        bypass_test();
        full_reclaim_test();
        flush_test("flush_exception", 1'b0);
        flush_test("flush_mret", 1'b1);
        random_test();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
src/mul_rs_pkg.sv
src/rs_queue_ctrl.sv
src/rs_entry_array.sv
src/rs_tag_wakeup.sv
src/rs_issue_select.sv
src/mul_reservation_station.sv
verif/mul_rs_tb.sv
